/* rtl/mips_core_pkg.sv */
// core-wide data types; all words are 32 bits and all accesses are word sized
`default_nettype none

package mips_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // next-pc source where hold covers a stalled bus access
  typedef enum logic [1:0] {
    PC_HOLD,
    PC_PLUS4,
    PC_BRANCH,
    PC_JUMP
  } pc_sel_t;

endpackage

`default_nettype wire

/* rtl/mips_isa_pkg.sv */
// MIPS32 encodings for the supported subset only (addu subu and or slt addiu lui lw sw beq j)
`default_nettype none

package mips_isa_pkg;

  // primary opcodes
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // funct field of r-type instructions
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_SLT  = 6'h2a;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_t;

  function automatic logic [5:0] instr_opcode(input logic [31:0] instr);
    return instr[31:26];
  endfunction

  function automatic logic [4:0] instr_rs(input logic [31:0] instr);
    return instr[25:21];
  endfunction

  function automatic logic [4:0] instr_rt(input logic [31:0] instr);
    return instr[20:16];
  endfunction

  function automatic logic [4:0] instr_rd(input logic [31:0] instr);
    return instr[15:11];
  endfunction

  function automatic logic [5:0] instr_funct(input logic [31:0] instr);
    return instr[5:0];
  endfunction

  function automatic logic [15:0] instr_imm(input logic [31:0] instr);
    return instr[15:0];
  endfunction

  function automatic logic [25:0] instr_index(input logic [31:0] instr);
    return instr[25:0];
  endfunction

endpackage

`default_nettype wire

/* rtl/ctrl_if.sv */
// decoded control bundle; reg_write and pc_sel already account for the memory stall
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
  import mips_core_pkg::*;
  import mips_isa_pkg::*;

  logic    reg_write;
  logic    reg_dst;
  logic    alu_src_imm;
  logic    lui;
  alu_op_t alu_op;
  logic    mem_read;
  logic    mem_write;
  pc_sel_t pc_sel;

  modport ctl (
    output reg_write, reg_dst, alu_src_imm, lui, alu_op, mem_read, mem_write, pc_sel
  );

  // register file and ALU side
  modport dp (input reg_write, reg_dst, alu_src_imm, lui, alu_op);

  // bus and program counter side
  modport mem (input mem_read, mem_write, pc_sel);

endinterface

`default_nettype wire

/* rtl/control_unit.sv */
// pure combinational decode; unknown opcodes and functs act as a nop that advances pc
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  mips_core_pkg::word_t instr,
  input  logic                 zero,
  input  logic                 stall,
  ctrl_if.ctl                  ctrl
);
  import mips_core_pkg::*;
  import mips_isa_pkg::*;

  logic wr_raw;
  logic is_beq;
  logic is_j;

  always_comb begin
    wr_raw           = 1'b0;
    is_beq           = 1'b0;
    is_j             = 1'b0;
    ctrl.reg_dst     = 1'b0;
    ctrl.alu_src_imm = 1'b0;
    ctrl.lui         = 1'b0;
    ctrl.alu_op      = ALU_ADD;
    ctrl.mem_read    = 1'b0;
    ctrl.mem_write   = 1'b0;
    case (instr_opcode(instr))
      OP_RTYPE: begin
        ctrl.reg_dst = 1'b1;
        wr_raw       = 1'b1;
        case (instr_funct(instr))
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          default: wr_raw = 1'b0;
        endcase
      end
      OP_ADDIU: begin
        wr_raw           = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      OP_LUI: begin
        wr_raw      = 1'b1;
        ctrl.lui    = 1'b1;
        ctrl.alu_op = ALU_PASS_B;
      end
      OP_LW: begin
        wr_raw           = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      OP_BEQ: begin
        ctrl.alu_op = ALU_SUB;
        is_beq      = 1'b1;
      end
      OP_J:    is_j = 1'b1;
      default: ;
    endcase
  end

  // a stalled access must neither retire nor write back
  assign ctrl.reg_write = wr_raw & ~stall;

  always_comb begin
    if (stall) ctrl.pc_sel = PC_HOLD;
    else if (is_beq && zero) ctrl.pc_sel = PC_BRANCH;
    else if (is_j) ctrl.pc_sel = PC_JUMP;
    else ctrl.pc_sel = PC_PLUS4;
  end

  always_comb begin
    a_rw_exclusive : assert (!(ctrl.mem_read && ctrl.mem_write))
      else $error("load and store decoded together");
  end

endmodule

`default_nettype wire

/* rtl/regfile.sv */
// 32 x 32 registers, r0 reads as zero, writes land on the rising edge after decode
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                 clk,
  input  logic                 reset,
  ctrl_if.dp                   ctrl,
  input  mips_core_pkg::word_t instr,
  input  mips_core_pkg::word_t wd,
  output mips_core_pkg::word_t rd1,
  output mips_core_pkg::word_t rd2,
  output mips_core_pkg::word_t reg_v0
);
  import mips_core_pkg::*;
  import mips_isa_pkg::*;

  word_t    rf [32];
  reg_idx_t ra1;
  reg_idx_t ra2;
  reg_idx_t wa;

  assign ra1 = instr_rs(instr);
  assign ra2 = instr_rt(instr);
  // r-type writes rd, immediate forms write rt
  assign wa  = ctrl.reg_dst ? instr_rd(instr) : instr_rt(instr);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (ctrl.reg_write && wa != '0) begin
      rf[wa] <= wd;
    end
  end

  assign rd1    = (ra1 != '0) ? rf[ra1] : '0;
  assign rd2    = (ra2 != '0) ? rf[ra2] : '0;
  assign reg_v0 = rf[2];

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
// single ALU with no overflow trap; slt compares as signed
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  ctrl_if.dp                   ctrl,
  input  mips_core_pkg::word_t instr,
  input  mips_core_pkg::word_t a,
  input  mips_core_pkg::word_t b,
  output mips_core_pkg::word_t result,
  output logic                 zero
);
  import mips_core_pkg::*;
  import mips_isa_pkg::*;

  word_t b_op;
  word_t imm_sext;

  assign imm_sext = {{16{instr[15]}}, instr_imm(instr)};

  // lui places the immediate in the upper half
  always_comb begin
    if (ctrl.lui) b_op = {instr_imm(instr), 16'h0000};
    else if (ctrl.alu_src_imm) b_op = imm_sext;
    else b_op = b;
  end

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    result = a + b_op;
      ALU_SUB:    result = a - b_op;
      ALU_AND:    result = a & b_op;
      ALU_OR:     result = a | b_op;
      ALU_SLT:    result = {31'b0, $signed(a) < $signed(b_op)};
      ALU_PASS_B: result = b_op;
      default:    result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

/* rtl/pc_unit.sv */
// no delay slots; branch and jump targets take effect on the very next fetch
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
  parameter mips_core_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
  input  logic                 clk,
  input  logic                 reset,
  ctrl_if.mem                  ctrl,
  input  mips_core_pkg::word_t instr,
  output mips_core_pkg::word_t pc
);
  import mips_core_pkg::*;
  import mips_isa_pkg::*;

  word_t pc_plus4;
  word_t branch_target;
  word_t jump_target;

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {{14{instr[15]}}, instr_imm(instr), 2'b00};
  // jump stays inside the current 256 MB region
  assign jump_target   = {pc_plus4[31:28], instr_index(instr), 2'b00};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= RESET_VECTOR;
    end else begin
      case (ctrl.pc_sel)
        PC_PLUS4:  pc <= pc_plus4;
        PC_BRANCH: pc <= branch_target;
        PC_JUMP:   pc <= jump_target;
        default:   pc <= pc;
      endcase
    end
  end

  a_pc_aligned : assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc left word alignment");

endmodule

`default_nettype wire

/* rtl/load_store_unit.sv */
// Wishbone classic master, word accesses only, no err or retry; one idle cycle follows each ack
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  input  logic                 clk,
  input  logic                 reset,
  ctrl_if.mem                  ctrl,
  input  mips_core_pkg::word_t addr,
  input  mips_core_pkg::word_t store_data,
  input  mips_core_pkg::word_t alu_result,
  output mips_core_pkg::word_t wb_value,
  output logic                 stall,
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic                 wb_we,
  output mips_core_pkg::word_t wb_adr,
  output mips_core_pkg::word_t wb_dat_o,
  output logic [3:0]           wb_sel,
  input  mips_core_pkg::word_t wb_dat_i,
  input  logic                 wb_ack
);
  import mips_core_pkg::*;

  logic req;
  logic done;

  assign req = ctrl.mem_read | ctrl.mem_write;

  // done marks the cycle after ack so the retiring access is not reissued
  always_ff @(posedge clk or posedge reset) begin
    if (reset) done <= 1'b0;
    else done <= wb_cyc & wb_ack;
  end

  assign wb_cyc   = req & ~done;
  assign wb_stb   = wb_cyc;
  assign wb_we    = wb_cyc & ctrl.mem_write;
  assign wb_adr   = addr;
  assign wb_dat_o = store_data;
  assign wb_sel   = 4'hF;

  // a memory op waiting behind done also has to hold
  assign stall    = req & ~(wb_cyc & wb_ack);

  assign wb_value = ctrl.mem_read ? wb_dat_i : alu_result;

  a_stb_in_cyc : assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
    else $error("stb raised outside a bus cycle");

  // address and direction stay steady while the slave withholds ack
  a_req_steady : assert property (@(posedge clk) disable iff (reset)
      wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr) && $stable(wb_we))
    else $error("bus request changed before ack");

endmodule

`default_nettype wire

/* rtl/mips_core.sv */
// single-cycle MIPS32 subset core; instruction port must answer in the same cycle
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
  parameter mips_core_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
  input  logic                 clk,
  input  logic                 reset,
  output mips_core_pkg::word_t imem_addr,
  input  mips_core_pkg::word_t imem_data,
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic                 wb_we,
  output mips_core_pkg::word_t wb_adr,
  output mips_core_pkg::word_t wb_dat_o,
  output logic [3:0]           wb_sel,
  input  mips_core_pkg::word_t wb_dat_i,
  input  logic                 wb_ack,
  output mips_core_pkg::word_t reg_v0
);
  import mips_core_pkg::*;

  word_t rd1;
  word_t rd2;
  word_t alu_result;
  word_t wb_value;
  logic  zero;
  logic  stall;

  ctrl_if ctrl ();

  control_unit u_control (
    .instr (imem_data),
    .zero  (zero),
    .stall (stall),
    .ctrl  (ctrl)
  );

  regfile u_regfile (
    .clk    (clk),
    .reset  (reset),
    .ctrl   (ctrl),
    .instr  (imem_data),
    .wd     (wb_value),
    .rd1    (rd1),
    .rd2    (rd2),
    .reg_v0 (reg_v0)
  );

  execute_unit u_execute (
    .ctrl   (ctrl),
    .instr  (imem_data),
    .a      (rd1),
    .b      (rd2),
    .result (alu_result),
    .zero   (zero)
  );

  pc_unit #(
    .RESET_VECTOR (RESET_VECTOR)
  ) u_pc (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .instr (imem_data),
    .pc    (imem_addr)
  );

  // effective address comes straight from the ALU, store data from rt
  load_store_unit u_lsu (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .addr       (alu_result),
    .store_data (rd2),
    .alu_result (alu_result),
    .wb_value   (wb_value),
    .stall      (stall),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_o   (wb_dat_o),
    .wb_sel     (wb_sel),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack)
  );

endmodule

`default_nettype wire

/* sim/wb_data_mem.sv */
// Wishbone classic slave model with 256 words at adr[9:2], 0 to 3 wait states per access
`timescale 1ns/1ps
`default_nettype none

module wb_data_mem (
  input  logic        clk,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [31:0] wdata,
  input  logic [3:0]  sel,
  output logic [31:0] rdata,
  output logic        ack
);
  logic [31:0] mem [256];
  logic [1:0]  waits;
  logic [1:0]  count;
  logic [7:0]  idx;

  assign idx   = adr[9:2];
  assign rdata = mem[idx];
  // zero wait states means ack in the same cycle as stb
  assign ack   = cyc && stb && (count == waits);

  // fill pattern built from the whole word index
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hc0de_0000 ^ {i[15:0], ~i[15:0]};
    end
  end

  // a new wait count is drawn once each access is acknowledged
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= 2'd0;
      waits <= 2'($urandom_range(3, 0));
    end else if (cyc && stb) begin
      if (ack) begin
        count <= 2'd0;
        waits <= 2'($urandom_range(3, 0));
      end else begin
        count <= count + 2'd1;
      end
    end
  end

  always @(posedge clk) begin
    if (ack && we) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) mem[idx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_mips_core.sv */
// 64-word instruction ROM at the reset vector; each program must end in a self-loop jump
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
  localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;
  localparam logic [31:0] SEED         = 32'h472f_aa89;
  localparam int          RESET_CYCLES = 16;
  // 14 program runs of 200 cycles, each with up to 3 bus accesses of at most 4 cycles
  localparam int          WATCHDOG_CYCLES = 14 * (200 + 3 * 4);

  // MIPS32 encodings used by the test programs
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] FN_ADDU  = 6'h21;
  localparam logic [5:0] FN_SUBU  = 6'h23;
  localparam logic [5:0] FN_AND   = 6'h24;
  localparam logic [5:0] FN_OR    = 6'h25;
  localparam logic [5:0] FN_SLT   = 6'h2a;

  logic        clk;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_o;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_i;
  logic        wb_ack;
  logic [31:0] reg_v0;
  logic [31:0] rom [64];
  logic [31:0] rom_offset;
  logic [31:0] prog [$];

  // combinational fetch that returns a nop outside the ROM
  assign rom_offset = imem_addr - RESET_VECTOR;
  assign imem_data  = (rom_offset < 32'd256) ? rom[rom_offset[7:2]] : 32'h0;

  mips_core #(
    .RESET_VECTOR (RESET_VECTOR)
  ) UUT (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_o  (wb_dat_o),
    .wb_sel    (wb_sel),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack),
    .reg_v0    (reg_v0)
  );

  wb_data_mem dmem (
    .clk   (clk),
    .reset (reset),
    .cyc   (wb_cyc),
    .stb   (wb_stb),
    .we    (wb_we),
    .adr   (wb_adr),
    .wdata (wb_dat_o),
    .sel   (wb_sel),
    .rdata (wb_dat_i),
    .ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rtype(input logic [5:0] funct, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'h00, funct};
  endfunction

  // arguments follow the encoding order of op rs rt and imm
  function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jump_to(input logic [31:0] target);
    return {6'h02, target[27:2]};
  endfunction

  function automatic logic [31:0] sext16(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    assert (actual === expected)
      else begin
        $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        $display("TEST FAILED");
        $fatal(1, "%s mismatch", name);
      end
  endtask

  // every bus cycle carries stb and enables all four byte lanes
  always @(negedge clk) begin
    if (!reset && wb_cyc) begin
      expect_equal("wb_stb", {31'b0, wb_stb}, 32'h1);
      expect_equal("wb_sel", {28'b0, wb_sel}, 32'h0000_000f);
    end
  end

  task automatic halt_here();
    prog.push_back(jump_to(RESET_VECTOR + 32'(prog.size() * 4)));
  endtask

  // the ROM is reloaded while reset holds the core
  task automatic pulse_reset();
    @(negedge clk);
    reset = 1'b1;
    for (int i = 0; i < 64; i++) begin
      rom[i] = (i < prog.size()) ? prog[i] : 32'h0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    expect_equal("imem_addr", imem_addr, RESET_VECTOR);
    expect_equal("wb_cyc", {31'b0, wb_cyc}, 32'h0);
    expect_equal("reg_v0", reg_v0, 32'h0);
  endtask

  task automatic run_program();
    logic [31:0] end_addr;
    end_addr = RESET_VECTOR + 32'((prog.size() - 1) * 4);
    pulse_reset();
    while (imem_addr !== end_addr) begin
      @(negedge clk);
    end
  endtask

  task automatic check_reset_values();
    prog.delete();
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd2, 16'h07e5));
    halt_here();
    run_program();
    expect_equal("reg_v0", reg_v0, 32'h0000_07e5);
    // second reset has to clear v0 again
    pulse_reset();
  endtask

  task automatic one_alu_op(input logic [5:0] funct, input logic [15:0] x,
                            input logic [15:0] y);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
    a = sext16(x);
    b = sext16(y);
    case (funct)
      FN_ADDU: expected = a + b;
      FN_SUBU: expected = a - b;
      FN_AND:  expected = a & b;
      FN_OR:   expected = a | b;
      default: expected = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
    prog.delete();
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd8, x));
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd9, y));
    prog.push_back(rtype(funct, 5'd2, 5'd8, 5'd9));
    halt_here();
    run_program();
    expect_equal("reg_v0", reg_v0, expected);
  endtask

  task automatic run_alu_ops();
    logic [15:0] x;
    logic [15:0] y;
    x = 16'($urandom);
    y = 16'($urandom);
    one_alu_op(FN_ADDU, x, y);
    one_alu_op(FN_SUBU, x, y);
    one_alu_op(FN_AND, x, y);
    one_alu_op(FN_OR, x, y);
    one_alu_op(FN_SLT, x, y);
    // -5 against 3 in both orders
    one_alu_op(FN_SLT, 16'hfffb, 16'h0003);
    one_alu_op(FN_SLT, 16'h0003, 16'hfffb);
    one_alu_op(FN_SUBU, 16'h0002, 16'h0007);
  endtask

  task automatic build_constant();
    logic [15:0] hi;
    logic [15:0] lo;
    hi = 16'($urandom);
    // bit 15 set so addiu borrows from the upper half
    lo = 16'($urandom) | 16'h8000;
    prog.delete();
    prog.push_back(itype(OP_LUI, 5'd0, 5'd2, hi));
    prog.push_back(itype(OP_ADDIU, 5'd2, 5'd2, lo));
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd0, 16'h0055));
    // adding r0 must leave v0 unchanged
    prog.push_back(rtype(FN_ADDU, 5'd2, 5'd2, 5'd0));
    halt_here();
    run_program();
    expect_equal("reg_v0", reg_v0, {hi, 16'h0000} + sext16(lo));
  endtask

  task automatic store_then_load();
    logic [15:0] hi;
    logic [15:0] lo;
    logic [31:0] stored;
    hi = 16'($urandom);
    lo = 16'($urandom);
    stored = {hi, 16'h0000} + sext16(lo);
    prog.delete();
    prog.push_back(itype(OP_LUI, 5'd0, 5'd8, hi));
    prog.push_back(itype(OP_ADDIU, 5'd8, 5'd8, lo));
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd9, 16'h0040));
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd10, 16'h1234));
    // the second of these back-to-back accesses waits out the idle cycle
    prog.push_back(itype(OP_SW, 5'd9, 5'd8, 16'h0000));
    prog.push_back(itype(OP_SW, 5'd9, 5'd10, 16'h0004));
    prog.push_back(itype(OP_LW, 5'd9, 5'd2, 16'h0000));
    halt_here();
    run_program();
    expect_equal("dmem.mem[16]", dmem.mem[16], stored);
    expect_equal("dmem.mem[17]", dmem.mem[17], 32'h0000_1234);
    expect_equal("reg_v0", reg_v0, stored);
  endtask

  task automatic branch_and_jump();
    // taken beq skips the word that would set v0 to 0x99
    prog.delete();
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd2, 16'h0011));
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd8, 16'h0005));
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd9, 16'h0005));
    prog.push_back(itype(OP_BEQ, 5'd8, 5'd9, 16'h0001));
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd2, 16'h0099));
    prog.push_back(itype(OP_ADDIU, 5'd2, 5'd2, 16'h0022));
    halt_here();
    run_program();
    expect_equal("reg_v0", reg_v0, 32'h11 + 32'h22);
    // not-taken beq falls through and j then skips the clear of v0
    prog.delete();
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd2, 16'h0011));
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd8, 16'h0005));
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd9, 16'h0006));
    prog.push_back(itype(OP_BEQ, 5'd8, 5'd9, 16'h0001));
    prog.push_back(itype(OP_ADDIU, 5'd2, 5'd2, 16'h0100));
    prog.push_back(jump_to(RESET_VECTOR + 32'd28));
    prog.push_back(itype(OP_ADDIU, 5'd0, 5'd2, 16'h0000));
    prog.push_back(itype(OP_ADDIU, 5'd2, 5'd2, 16'h0002));
    halt_here();
    run_program();
    expect_equal("reg_v0", reg_v0, 32'h11 + 32'h100 + 32'h2);
  endtask

  initial begin
    void'($urandom(SEED));
    reset = 1'b1;
    for (int i = 0; i < 64; i++) begin
      rom[i] = 32'h0;
    end
    check_reset_values();
    run_alu_ops();
    build_constant();
    store_then_load();
    branch_and_jump();
    $display("TEST PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "simulation did not finish in time");
  end

endmodule

`default_nettype wire

/* mips_core.f */
rtl/mips_core_pkg.sv
rtl/mips_isa_pkg.sv
rtl/ctrl_if.sv
rtl/control_unit.sv
rtl/regfile.sv
rtl/execute_unit.sv
rtl/pc_unit.sv
rtl/load_store_unit.sv
rtl/mips_core.sv
sim/wb_data_mem.sv
sim/tb_mips_core.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mips_core -f mips_core.f \
  -o tb_mips_core \
  && ./obj_dir/tb_mips_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST PASSED" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
